// File: hw/zip_dbg_defs.svh
`ifndef ZIP_DBG_DEFS_SVH
`define ZIP_DBG_DEFS_SVH

////////////////////////////////////////////////////////////////////////////
// Debug bus geometry
////////////////////////////////////////////////////////////////////////////

// Debug data bus is one 32-bit word
`define ZD_DATA_W	32
// Byte address width of the debug slave
`define ZD_ADDR_W	8
// Byte address to word index
`define ZD_LSB		2

////////////////////////////////////////////////////////////////////////////
// Register map
////////////////////////////////////////////////////////////////////////////

// Word index bit picking the control register, byte offset 0x80
`define ZD_CTRL_SEL	5
// Control register bits
`define ZD_RESET_BIT	6
`define ZD_STEP_BIT	8
`define ZD_HALT_BIT	10
`define ZD_CLEAR_BIT	11

// Cycles of reset hold after power-on or an external CPU reset
`define ZD_RESET_DURATION	10

`endif

// File: hw/zip_dbg_pkg.sv
`include "zip_dbg_defs.svh"

package zip_dbg_pkg;

	// One debug data word
	typedef logic [`ZD_DATA_W-1:0] word_t;
	// Word index, register number plus control select
	typedef logic [`ZD_ADDR_W-`ZD_LSB-1:0] widx_t;
	// CPU register number
	typedef logic [`ZD_CTRL_SEL-1:0] reg_t;
	// Byte lanes of one word
	typedef logic [`ZD_DATA_W/8-1:0] strb_t;
	// CPU condition flags
	typedef logic [2:0] cc_t;

	// One accepted debug write, address and data joined
	typedef struct packed
	{
		widx_t	idx;
		word_t	data;
		strb_t	strb;
	} dbg_cmd_t;

	// Register write toward the CPU core
	typedef struct packed
	{
		logic	we;
		reg_t	wreg;
		word_t	data;
	} cpu_dbg_req_t;

	// Debug status back from the CPU core
	typedef struct packed
	{
		logic	stall;
		logic	brk;
		cc_t	cc;
	} cpu_dbg_stat_t;

endpackage

// File: hw/dbg_skid_buffer.sv
module dbg_skid_buffer #(
	parameter int WIDTH = 8
) (
	input	logic			S_AXI_ACLK,
	input	logic			S_AXI_ARESETN,
	// Upstream, the AXI-lite master side
	input	logic			i_valid,
	output	logic			o_ready,
	input	logic	[WIDTH-1:0]	i_data,
	// Downstream, the accept logic
	output	logic			o_valid,
	input	logic			i_ready,
	output	logic	[WIDTH-1:0]	o_data
);

	// Skid slot
	logic			r_valid;
	logic	[WIDTH-1:0]	r_data;

	////////////////////////////////////////////////////////////////////////////
	// Skid slot control
	////////////////////////////////////////////////////////////////////////////

	// Fill when an item arrives and downstream stalls
	// Drain as soon as downstream takes it
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			r_valid <= 1'b0;
		else if (i_valid && o_ready && !i_ready)
			r_valid <= 1'b1;
		else if (i_ready)
			r_valid <= 1'b0;
	end

	// Capture whatever is on the bus while empty
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (o_ready)
			r_data <= i_data;
	end

	////////////////////////////////////////////////////////////////////////////
	// Outputs
	////////////////////////////////////////////////////////////////////////////

	// Ready only from an empty slot, so AXI ready is a plain flop
	assign o_ready = !r_valid;

	// Held item first, else pass through
	assign o_valid = i_valid || r_valid;
	assign o_data = r_valid ? r_data : i_data;

endmodule

// File: hw/dbg_write_path.sv
`include "zip_dbg_defs.svh"

module dbg_write_path (
	input	logic				S_AXI_ACLK,
	input	logic				S_AXI_ARESETN,
	// Write address channel
	input	logic				S_DBG_AWVALID,
	output	logic				S_DBG_AWREADY,
	input	logic	[`ZD_ADDR_W-1:0]	S_DBG_AWADDR,
	// Write data channel
	input	logic				S_DBG_WVALID,
	output	logic				S_DBG_WREADY,
	input	zip_dbg_pkg::word_t		S_DBG_WDATA,
	input	zip_dbg_pkg::strb_t		S_DBG_WSTRB,
	// Write response channel
	output	logic				S_DBG_BVALID,
	input	logic				S_DBG_BREADY,
	output	logic	[1:0]			S_DBG_BRESP,
	// CPU side
	input	zip_dbg_pkg::cpu_dbg_stat_t	i_cpu_stat,
	output	logic				o_cmd_stb,
	output	zip_dbg_pkg::dbg_cmd_t		o_cmd,
	output	zip_dbg_pkg::cpu_dbg_req_t	o_cpu_req
);

	localparam int WW = $bits(zip_dbg_pkg::word_t) + $bits(zip_dbg_pkg::strb_t);

	logic			aw_valid, w_valid;
	logic			write_ready, write_stall, is_ctrl;
	zip_dbg_pkg::widx_t	aw_idx;
	logic	[WW-1:0]	w_skd;
	zip_dbg_pkg::word_t	w_data;
	zip_dbg_pkg::strb_t	w_strb;
	// Registered CPU write request
	logic			req_we;
	zip_dbg_pkg::reg_t	req_reg;
	zip_dbg_pkg::word_t	req_data;

	// Address skid, word index only
	dbg_skid_buffer #(.WIDTH($bits(zip_dbg_pkg::widx_t))) u_aw_skd (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.i_valid(S_DBG_AWVALID), .o_ready(S_DBG_AWREADY),
		.i_data(S_DBG_AWADDR[`ZD_ADDR_W-1:`ZD_LSB]),
		.o_valid(aw_valid), .i_ready(write_ready), .o_data(aw_idx)
	);

	// Data and strobe skid
	dbg_skid_buffer #(.WIDTH(WW)) u_w_skd (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.i_valid(S_DBG_WVALID), .o_ready(S_DBG_WREADY),
		.i_data({S_DBG_WDATA, S_DBG_WSTRB}),
		.o_valid(w_valid), .i_ready(write_ready), .o_data(w_skd)
	);

	assign w_data = w_skd[WW-1:$bits(zip_dbg_pkg::strb_t)];
	assign w_strb = w_skd[$bits(zip_dbg_pkg::strb_t)-1:0];
	assign is_ctrl = aw_idx[`ZD_CTRL_SEL];

	// Previous CPU write still pending in the core
	assign write_stall = req_we && i_cpu_stat.stall;

	// Both halves present, B free, and no CPU write in the way
	assign write_ready = aw_valid && w_valid
		&& ((w_strb == '0) || is_ctrl || !write_stall)
		&& (!S_DBG_BVALID || S_DBG_BREADY);

	// Every accepted write goes to the command logic
	assign o_cmd_stb = write_ready;
	assign o_cmd = {aw_idx, w_data, w_strb};

	////////////////////////////////////////////////////////////////////////////
	// CPU register write request
	////////////////////////////////////////////////////////////////////////////

	// Frozen while the core stalls
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			req_we <= 1'b0;
		else if (!write_stall)
			req_we <= write_ready && (|w_strb) && !is_ctrl;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!write_stall)
		begin
			req_reg <= aw_idx[`ZD_CTRL_SEL-1:0];
			req_data <= w_data;
		end
	end

	assign o_cpu_req = {req_we, req_reg, req_data};

	// B follows acceptance by one cycle, holds until taken
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			S_DBG_BVALID <= 1'b0;
		else if (write_ready)
			S_DBG_BVALID <= 1'b1;
		else if (S_DBG_BREADY)
			S_DBG_BVALID <= 1'b0;
	end

	// Always OKAY
	assign S_DBG_BRESP = 2'b00;

endmodule

// File: hw/dbg_read_path.sv
`include "zip_dbg_defs.svh"

module dbg_read_path (
	input	logic				S_AXI_ACLK,
	input	logic				S_AXI_ARESETN,
	// Read address channel
	input	logic				S_DBG_ARVALID,
	output	logic				S_DBG_ARREADY,
	input	logic	[`ZD_ADDR_W-1:0]	S_DBG_ARADDR,
	// Read data channel
	output	logic				S_DBG_RVALID,
	input	logic				S_DBG_RREADY,
	output	zip_dbg_pkg::word_t		S_DBG_RDATA,
	output	logic	[1:0]			S_DBG_RRESP,
	// CPU register port and status
	output	zip_dbg_pkg::reg_t		o_dbg_rreg,
	input	zip_dbg_pkg::word_t		i_dbg_rdata,
	input	zip_dbg_pkg::word_t		i_status
);

	logic			ar_valid, read_ready, rd_pend, is_ctrl;
	zip_dbg_pkg::widx_t	ar_idx;

	// Address skid, word index only
	dbg_skid_buffer #(.WIDTH($bits(zip_dbg_pkg::widx_t))) u_ar_skd (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.i_valid(S_DBG_ARVALID), .o_ready(S_DBG_ARREADY),
		.i_data(S_DBG_ARADDR[`ZD_ADDR_W-1:`ZD_LSB]),
		.o_valid(ar_valid), .i_ready(read_ready), .o_data(ar_idx)
	);

	assign is_ctrl = ar_idx[`ZD_CTRL_SEL];

	// One read in flight at a time, R free or emptying
	assign read_ready = ar_valid && !rd_pend && (!S_DBG_RVALID || S_DBG_RREADY);

	// Register number straight to the core during acceptance
	assign o_dbg_rreg = ar_idx[`ZD_CTRL_SEL-1:0];

	// CPU register data one cycle out
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			rd_pend <= 1'b0;
		else
			rd_pend <= read_ready && !is_ctrl;
	end

	////////////////////////////////////////////////////////////////////////////
	// R channel
	////////////////////////////////////////////////////////////////////////////

	// Status a cycle after accept, register two cycles after
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			S_DBG_RVALID <= 1'b0;
		else if (!S_DBG_RVALID || S_DBG_RREADY)
			S_DBG_RVALID <= (read_ready && is_ctrl) || rd_pend;
	end

	// Data held along with RVALID
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_DBG_RVALID || S_DBG_RREADY)
			S_DBG_RDATA <= rd_pend ? i_dbg_rdata : i_status;
	end

	assign S_DBG_RRESP = 2'b00;

endmodule

// File: hw/cpu_cmd_ctrl.sv
`include "zip_dbg_defs.svh"

module cpu_cmd_ctrl (
	input	logic				S_AXI_ACLK,
	input	logic				S_AXI_ARESETN,
	input	logic				i_cpu_reset,
	input	logic				i_interrupt,
	// Accepted debug write
	input	logic				i_cmd_stb,
	input	zip_dbg_pkg::dbg_cmd_t		i_cmd,
	// CPU port state
	input	zip_dbg_pkg::cpu_dbg_req_t	i_cpu_wr,
	input	zip_dbg_pkg::cpu_dbg_stat_t	i_cpu_stat,
	// Commands toward the core
	output	logic				o_cmd_reset,
	output	logic				o_halt,
	output	logic				o_step,
	output	logic				o_clear_cache,
	output	zip_dbg_pkg::word_t		o_status
);

	localparam int CNT_W = $clog2(`ZD_RESET_DURATION + 1);

	logic			reset_hold, cmd_write, reg_write, wr_stall;
	logic	[CNT_W-1:0]	reset_counter;

	// Control register writes versus CPU register writes
	assign cmd_write = i_cmd_stb && i_cmd.idx[`ZD_CTRL_SEL];
	assign reg_write = i_cmd_stb && !i_cmd.idx[`ZD_CTRL_SEL] && (|i_cmd.strb);
	assign wr_stall = i_cpu_wr.we && i_cpu_stat.stall;

	////////////////////////////////////////////////////////////////////////////
	// Reset hold
	////////////////////////////////////////////////////////////////////////////

	// Reload on bus reset or external CPU reset, then count down
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || i_cpu_reset)
			reset_counter <= CNT_W'(`ZD_RESET_DURATION);
		else if (reset_counter != '0)
			reset_counter <= reset_counter - 1'b1;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || i_cpu_reset)
			reset_hold <= 1'b1;
		else
			reset_hold <= (reset_counter > CNT_W'(1));
	end

	// Held, broken CPU, or reset bit in byte 0
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || i_cpu_reset || reset_hold || i_cpu_stat.brk)
			o_cmd_reset <= 1'b1;
		else
			o_cmd_reset <= cmd_write && i_cmd.strb[0] && i_cmd.data[`ZD_RESET_BIT];
	end

	////////////////////////////////////////////////////////////////////////////
	// Halt, step, clear-cache
	////////////////////////////////////////////////////////////////////////////

	// Later assignments win, so set reasons override release
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_halt <= 1'b0;
		else if (i_cpu_reset && !i_cmd_stb && !wr_stall)
			o_halt <= 1'b0;
		else
		begin
			// Release on halt clear or step, once the core is idle
			if (!i_cpu_wr.we && !i_cpu_stat.stall && cmd_write && i_cmd.strb[1]
				&& (!i_cmd.data[`ZD_HALT_BIT] || i_cmd.data[`ZD_STEP_BIT]))
				o_halt <= 1'b0;
			// Halt request without step
			if (cmd_write && i_cmd.strb[1] && i_cmd.data[`ZD_HALT_BIT]
				&& !i_cmd.data[`ZD_STEP_BIT])
				o_halt <= 1'b1;
			// Any CPU register write
			if (reg_write)
				o_halt <= 1'b1;
			// Back to halt after a step or cache clear
			if (o_step || o_clear_cache)
				o_halt <= 1'b1;
			// Clear bit halts on its own
			if (cmd_write && i_cmd.strb[1] && i_cmd.data[`ZD_CLEAR_BIT])
				o_halt <= 1'b1;
		end
	end

	// Needs halt and clear together, done once the core is idle
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || o_cmd_reset)
			o_clear_cache <= 1'b0;
		else if (cmd_write && i_cmd.strb[1] && i_cmd.data[`ZD_CLEAR_BIT]
			&& i_cmd.data[`ZD_HALT_BIT])
			o_clear_cache <= 1'b1;
		else if (o_halt && !i_cpu_stat.stall)
			o_clear_cache <= 1'b0;
	end

	// Single step, dropped when the core accepts it
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || i_cpu_reset)
			o_step <= 1'b0;
		else if (cmd_write && i_cmd.strb[1] && i_cmd.data[`ZD_STEP_BIT])
			o_step <= 1'b1;
		else if (!i_cpu_stat.stall)
			o_step <= 1'b0;
	end

	// Status word
	// 16 interrupt, 15 break, 14..12 cc, 10 halt, 9 halted, 7 interrupt, 6 reset
	assign o_status = {15'h0, i_interrupt, i_cpu_stat.brk, i_cpu_stat.cc,
		1'b0, o_halt, !i_cpu_stat.stall, 1'b0,
		i_interrupt, o_cmd_reset, 6'h0};

endmodule

// File: hw/zip_dbg_top.sv
`include "zip_dbg_defs.svh"

module zip_dbg_top (
	input	logic				S_AXI_ACLK,
	input	logic				S_AXI_ARESETN,
	input	logic				i_interrupt,
	input	logic				i_cpu_reset,
	// AXI-lite debug slave
	input	logic				S_DBG_AWVALID,
	output	logic				S_DBG_AWREADY,
	input	logic	[`ZD_ADDR_W-1:0]	S_DBG_AWADDR,
	input	logic				S_DBG_WVALID,
	output	logic				S_DBG_WREADY,
	input	zip_dbg_pkg::word_t		S_DBG_WDATA,
	input	zip_dbg_pkg::strb_t		S_DBG_WSTRB,
	output	logic				S_DBG_BVALID,
	input	logic				S_DBG_BREADY,
	output	logic	[1:0]			S_DBG_BRESP,
	input	logic				S_DBG_ARVALID,
	output	logic				S_DBG_ARREADY,
	input	logic	[`ZD_ADDR_W-1:0]	S_DBG_ARADDR,
	output	logic				S_DBG_RVALID,
	input	logic				S_DBG_RREADY,
	output	zip_dbg_pkg::word_t		S_DBG_RDATA,
	output	logic	[1:0]			S_DBG_RRESP,
	// CPU core debug port
	output	zip_dbg_pkg::cpu_dbg_req_t	o_cpu_req,
	output	zip_dbg_pkg::reg_t		o_dbg_rreg,
	input	zip_dbg_pkg::word_t		i_dbg_rdata,
	input	zip_dbg_pkg::cpu_dbg_stat_t	i_cpu_stat,
	output	logic				o_cmd_reset,
	output	logic				o_halt,
	output	logic				o_step,
	output	logic				o_clear_cache
);

	logic			cmd_stb;
	zip_dbg_pkg::dbg_cmd_t	cmd;
	zip_dbg_pkg::word_t	status;

	// AW, W, B and CPU register writes
	dbg_write_path u_write (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.S_DBG_AWVALID(S_DBG_AWVALID), .S_DBG_AWREADY(S_DBG_AWREADY),
		.S_DBG_AWADDR(S_DBG_AWADDR),
		.S_DBG_WVALID(S_DBG_WVALID), .S_DBG_WREADY(S_DBG_WREADY),
		.S_DBG_WDATA(S_DBG_WDATA), .S_DBG_WSTRB(S_DBG_WSTRB),
		.S_DBG_BVALID(S_DBG_BVALID), .S_DBG_BREADY(S_DBG_BREADY),
		.S_DBG_BRESP(S_DBG_BRESP),
		.i_cpu_stat(i_cpu_stat), .o_cmd_stb(cmd_stb), .o_cmd(cmd),
		.o_cpu_req(o_cpu_req)
	);

	// AR and R, status or CPU register
	dbg_read_path u_read (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.S_DBG_ARVALID(S_DBG_ARVALID), .S_DBG_ARREADY(S_DBG_ARREADY),
		.S_DBG_ARADDR(S_DBG_ARADDR),
		.S_DBG_RVALID(S_DBG_RVALID), .S_DBG_RREADY(S_DBG_RREADY),
		.S_DBG_RDATA(S_DBG_RDATA), .S_DBG_RRESP(S_DBG_RRESP),
		.o_dbg_rreg(o_dbg_rreg), .i_dbg_rdata(i_dbg_rdata), .i_status(status)
	);

	// Reset hold, halt, step, clear-cache and status
	cpu_cmd_ctrl u_ctrl (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.i_cpu_reset(i_cpu_reset), .i_interrupt(i_interrupt),
		.i_cmd_stb(cmd_stb), .i_cmd(cmd),
		.i_cpu_wr(o_cpu_req), .i_cpu_stat(i_cpu_stat),
		.o_cmd_reset(o_cmd_reset), .o_halt(o_halt), .o_step(o_step),
		.o_clear_cache(o_clear_cache), .o_status(status)
	);

endmodule

// File: testbench/dbg_checker.sv
module dbg_checker (
	input	logic				i_clk,
	input	logic				i_rstn,
	// Response channels
	input	logic				i_bvalid,
	input	logic				i_bready,
	input	logic	[1:0]			i_bresp,
	input	logic				i_rvalid,
	input	logic				i_rready,
	input	zip_dbg_pkg::word_t		i_rdata,
	input	logic	[1:0]			i_rresp,
	// CPU side
	input	zip_dbg_pkg::cpu_dbg_req_t	i_cpu_req,
	input	logic				i_cpu_stall,
	input	logic				i_step
);

	int			errors, checks, b_seen, r_seen, step_cnt;
	// Expected read data and CPU writes, in order
	zip_dbg_pkg::word_t		exp_rd[$];
	zip_dbg_pkg::cpu_dbg_req_t	exp_req[$];

	initial
	begin
		errors = 0;
		checks = 0;
		b_seen = 0;
		r_seen = 0;
		step_cnt = 0;
	end

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (exp !== act)
		begin
			errors++;
			$display("FAILED %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic report_error(input string msg);
		errors++;
		$display("Error: %s", msg);
	endtask

	task automatic expect_read(input zip_dbg_pkg::word_t value);
		exp_rd.push_back(value);
	endtask

	task automatic expect_req(input zip_dbg_pkg::reg_t r, input zip_dbg_pkg::word_t d);
		exp_req.push_back({1'b1, r, d});
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Handshake monitor
	////////////////////////////////////////////////////////////////////////////

	always @(posedge i_clk)
	begin
		zip_dbg_pkg::cpu_dbg_req_t e;
		if (i_rstn)
		begin
			// Responses are OKAY only
			if (i_bvalid && i_bready)
			begin
				b_seen++;
				check_value("bresp", 32'h0, 32'(i_bresp));
			end
			// Read data against the oldest expectation
			if (i_rvalid && i_rready)
			begin
				r_seen++;
				check_value("rresp", 32'h0, 32'(i_rresp));
				if (exp_rd.size() == 0)
					report_error("read response arrived with no read outstanding");
				else
					check_value("read_data", exp_rd.pop_front(), i_rdata);
			end
			// CPU write taken when the core is not stalled
			if (i_cpu_req.we && !i_cpu_stall)
			begin
				if (exp_req.size() == 0)
					report_error("CPU register write that no bus write asked for");
				else
				begin
					e = exp_req.pop_front();
					check_value("req_reg", 32'(e.wreg), 32'(i_cpu_req.wreg));
					check_value("req_data", e.data, i_cpu_req.data);
				end
			end
			if (i_step)
				step_cnt++;
		end
	end

	// No lost or duplicated responses, nothing left over
	task automatic final_counts(input int b_issued, input int r_issued);
		check_value("b_count", 32'(b_issued), 32'(b_seen));
		check_value("r_count", 32'(r_issued), 32'(r_seen));
		if (exp_rd.size() != 0)
			report_error("read responses missing at the end of the run");
		if (exp_req.size() != 0)
			report_error("CPU register writes missing at the end of the run");
	endtask

endmodule

// File: testbench/tb_zip_dbg.sv
`include "zip_dbg_defs.svh"

module tb_zip_dbg;

	localparam int TMO = 200;
	localparam logic [7:0] CTRL = 8'h80;

	logic			aclk, aresetn, intr, cpu_reset;
	logic			awvalid, awready, wvalid, wready, bvalid, bready;
	logic			arvalid, arready, rvalid, rready;
	logic	[7:0]		awaddr, araddr;
	logic	[1:0]		bresp, rresp;
	zip_dbg_pkg::word_t	wdata, rdata, dbg_rdata;
	zip_dbg_pkg::strb_t	wstrb;
	zip_dbg_pkg::cpu_dbg_req_t	cpu_req;
	zip_dbg_pkg::reg_t	dbg_rreg;
	zip_dbg_pkg::cc_t	cpu_cc;
	logic			cpu_stall, cpu_brk, force_stall;
	logic			cmd_reset, halt, step, clear_cache, exp_halt;
	int			seed, stall_cnt, b_issued, r_issued, n, t, base;
	zip_dbg_pkg::word_t	cpu_regs[32];
	zip_dbg_pkg::word_t	shadow[32];

	always #4 aclk = ~aclk;

	zip_dbg_top dut0 (
		.S_AXI_ACLK(aclk), .S_AXI_ARESETN(aresetn),
		.i_interrupt(intr), .i_cpu_reset(cpu_reset),
		.S_DBG_AWVALID(awvalid), .S_DBG_AWREADY(awready), .S_DBG_AWADDR(awaddr),
		.S_DBG_WVALID(wvalid), .S_DBG_WREADY(wready),
		.S_DBG_WDATA(wdata), .S_DBG_WSTRB(wstrb),
		.S_DBG_BVALID(bvalid), .S_DBG_BREADY(bready), .S_DBG_BRESP(bresp),
		.S_DBG_ARVALID(arvalid), .S_DBG_ARREADY(arready), .S_DBG_ARADDR(araddr),
		.S_DBG_RVALID(rvalid), .S_DBG_RREADY(rready),
		.S_DBG_RDATA(rdata), .S_DBG_RRESP(rresp),
		.o_cpu_req(cpu_req), .o_dbg_rreg(dbg_rreg), .i_dbg_rdata(dbg_rdata),
		.i_cpu_stat({cpu_stall, cpu_brk, cpu_cc}),
		.o_cmd_reset(cmd_reset), .o_halt(halt), .o_step(step),
		.o_clear_cache(clear_cache)
	);

	dbg_checker chk0 (
		.i_clk(aclk), .i_rstn(aresetn),
		.i_bvalid(bvalid), .i_bready(bready), .i_bresp(bresp),
		.i_rvalid(rvalid), .i_rready(rready), .i_rdata(rdata), .i_rresp(rresp),
		.i_cpu_req(cpu_req), .i_cpu_stall(cpu_stall), .i_step(step)
	);

	// Register contents at power-on, from the whole index
	function automatic zip_dbg_pkg::word_t init_pattern(input int i);
		return (32'(i) * 32'h9e3779b1) ^ 32'h5a5a0f0f;
	endfunction

	// Reference status word
	function automatic zip_dbg_pkg::word_t expected_status(input logic rst, input logic irq,
		input logic halted, input logic hlt, input zip_dbg_pkg::cc_t cc, input logic brk);
		zip_dbg_pkg::word_t s;
		s = '0;
		s[6] = rst;
		s[7] = irq;
		s[9] = halted;
		s[10] = hlt;
		s[14:12] = cc;
		s[15] = brk;
		s[16] = irq;
		return s;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// CPU model
	////////////////////////////////////////////////////////////////////////////

	// Random stall after each taken write, register data one cycle after rreg
	always @(posedge aclk)
	begin
		if (!aresetn)
		begin
			stall_cnt = 0;
			cpu_stall <= 1'b0;
		end
		else
		begin
			if (cpu_req.we && !cpu_stall)
			begin
				cpu_regs[cpu_req.wreg] <= cpu_req.data;
				stall_cnt = $random(seed) & 3;
			end
			else if (stall_cnt > 0)
				stall_cnt = stall_cnt - 1;
			cpu_stall <= (stall_cnt != 0) || force_stall;
		end
		dbg_rdata <= cpu_regs[dbg_rreg];
	end

	////////////////////////////////////////////////////////////////////////////
	// Bus tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic axi_write(input logic [7:0] addr, input zip_dbg_pkg::word_t d);
		logic aw_done, w_done, got;
		int k;
		@(posedge aclk);
		awvalid <= 1'b1;
		awaddr <= addr;
		wvalid <= 1'b1;
		wdata <= d;
		wstrb <= 4'hf;
		aw_done = 1'b0;
		w_done = 1'b0;
		k = 0;
		while (!(aw_done && w_done) && k < TMO)
		begin
			@(posedge aclk);
			k++;
			if (awvalid && awready)
			begin
				aw_done = 1'b1;
				awvalid <= 1'b0;
			end
			if (wvalid && wready)
			begin
				w_done = 1'b1;
				wvalid <= 1'b0;
			end
		end
		if (!(aw_done && w_done))
			chk0.report_error("timeout waiting for AWREADY and WREADY");
		b_issued++;
		// Random BREADY until the response is taken
		got = 1'b0;
		k = 0;
		while (!got && k < TMO)
		begin
			@(posedge aclk);
			k++;
			if (bvalid && bready)
				got = 1'b1;
			bready <= got ? 1'b0 : (($random(seed) & 3) != 0);
		end
		if (!got)
			chk0.report_error("timeout waiting for the write response");
	endtask

	task automatic axi_read(input logic [7:0] addr, input zip_dbg_pkg::word_t exp);
		logic got;
		int k;
		chk0.expect_read(exp);
		@(posedge aclk);
		arvalid <= 1'b1;
		araddr <= addr;
		got = 1'b0;
		k = 0;
		while (!got && k < TMO)
		begin
			@(posedge aclk);
			k++;
			if (arvalid && arready)
			begin
				got = 1'b1;
				arvalid <= 1'b0;
			end
		end
		if (!got)
			chk0.report_error("timeout waiting for ARREADY");
		r_issued++;
		got = 1'b0;
		k = 0;
		while (!got && k < TMO)
		begin
			@(posedge aclk);
			k++;
			if (rvalid && rready)
				got = 1'b1;
			rready <= got ? 1'b0 : (($random(seed) & 3) != 0);
		end
		if (!got)
			chk0.report_error("timeout waiting for the read response");
	endtask

	// Core not stalled and no CPU write outstanding
	task automatic wait_cpu_idle();
		int k;
		k = 0;
		@(posedge aclk);
		while ((cpu_req.we || cpu_stall) && k < TMO)
		begin
			@(posedge aclk);
			k++;
		end
		if (k >= TMO)
			chk0.report_error("timeout waiting for the CPU to go idle");
	endtask

	// High cycles of o_cmd_reset, counted from the cycle after the triggering edge
	task automatic reset_hold_len(output int len);
		@(posedge aclk);
		len = 0;
		@(posedge aclk);
		while (cmd_reset && len < TMO)
		begin
			len++;
			@(posedge aclk);
		end
	endtask

	task automatic write_reg(input int r, input zip_dbg_pkg::word_t d);
		shadow[r] = d;
		chk0.expect_req(zip_dbg_pkg::reg_t'(r), d);
		axi_write({r[5:0], 2'b00}, d);
		exp_halt = 1'b1;
	endtask

	task automatic read_status();
		axi_read(CTRL, expected_status(1'b0, intr, 1'b1, exp_halt, cpu_cc, 1'b0));
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		seed = 32'h84ad0cb6;
		aclk = 1'b0;
		b_issued = 0;
		r_issued = 0;
		exp_halt = 1'b0;
		aresetn <= 1'b0;
		intr <= 1'b0;
		cpu_reset <= 1'b0;
		awvalid <= 1'b0;
		awaddr <= '0;
		wvalid <= 1'b0;
		wdata <= '0;
		wstrb <= '0;
		bready <= 1'b0;
		arvalid <= 1'b0;
		araddr <= '0;
		rready <= 1'b0;
		cpu_stall <= 1'b0;
		cpu_brk <= 1'b0;
		cpu_cc <= '0;
		force_stall <= 1'b0;
		dbg_rdata <= '0;
		for (int i = 0; i < 32; i++)
		begin
			cpu_regs[i] <= init_pattern(i);
			shadow[i] = init_pattern(i);
		end
		repeat (16) @(posedge aclk);
		aresetn <= 1'b1;

		// 1. Reset hold after release and after a CPU reset pulse
		reset_hold_len(n);
		chk0.check_value("reset_hold", `ZD_RESET_DURATION, 32'(n));
		@(posedge aclk);
		cpu_reset <= 1'b1;
		@(posedge aclk);
		cpu_reset <= 1'b0;
		reset_hold_len(n);
		chk0.check_value("cpu_reset_hold", `ZD_RESET_DURATION, 32'(n));

		// 2. Register writes, each one halts the CPU
		write_reg(3, $random(seed));
		chk0.check_value("halt_after_write", 1, 32'(halt));
		write_reg(17, $random(seed));
		write_reg(30, $random(seed));
		write_reg(0, $random(seed));

		// 3. Register reads, written and untouched
		foreach (shadow[i])
			if (i % 3 == 0 || i == 17)
				axi_read({i[5:0], 2'b00}, shadow[i]);

		// 4. Release the halt left by the register writes
		wait_cpu_idle();
		axi_write(CTRL, 32'h0);
		exp_halt = 1'b0;
		chk0.check_value("halt_release_writes", 0, 32'(halt));
		read_status();

		// Halt set and release
		axi_write(CTRL, 32'h1 << `ZD_HALT_BIT);
		exp_halt = 1'b1;
		chk0.check_value("halt_set", 1, 32'(halt));
		read_status();
		axi_write(CTRL, 32'h0);
		exp_halt = 1'b0;
		chk0.check_value("halt_release", 0, 32'(halt));
		read_status();

		// Step pulses once, then halts again
		base = chk0.step_cnt;
		axi_write(CTRL, 32'h1 << `ZD_STEP_BIT);
		repeat (3) @(posedge aclk);
		exp_halt = 1'b1;
		chk0.check_value("step_pulses", 1, 32'(chk0.step_cnt - base));
		chk0.check_value("halt_after_step", 1, 32'(halt));

		// Clear-cache held while the core stalls
		@(posedge aclk);
		force_stall <= 1'b1;
		repeat (2) @(posedge aclk);
		axi_write(CTRL, (32'h1 << `ZD_CLEAR_BIT) | (32'h1 << `ZD_HALT_BIT));
		repeat (4) @(posedge aclk);
		chk0.check_value("clear_cache_held", 1, 32'(clear_cache));
		force_stall <= 1'b0;
		t = 0;
		@(posedge aclk);
		while (clear_cache && t < TMO)
		begin
			@(posedge aclk);
			t++;
		end
		if (t >= TMO)
			chk0.report_error("o_clear_cache stayed high after the stall ended");

		// 5. Break pulses o_cmd_reset for one cycle
		wait_cpu_idle();
		cpu_brk <= 1'b1;
		@(posedge aclk);
		cpu_brk <= 1'b0;
		// High cycles within a short window after the break
		n = 0;
		repeat (6)
		begin
			@(posedge aclk);
			if (cmd_reset)
				n++;
		end
		chk0.check_value("break_reset_pulse", 1, 32'(n));

		// Status under random back-pressure
		for (int i = 0; i < 24; i++)
		begin
			@(posedge aclk);
			intr <= 1'($random(seed));
			cpu_cc <= zip_dbg_pkg::cc_t'($random(seed));
			@(posedge aclk);
			read_status();
		end
		repeat (4) @(posedge aclk);
		chk0.final_counts(b_issued, r_issued);

		$display("errors=%0d checks=%0d", chk0.errors, chk0.checks);
		if (chk0.errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// File: list.f
+incdir+hw
hw/zip_dbg_pkg.sv
hw/dbg_skid_buffer.sv
hw/dbg_write_path.sv
hw/dbg_read_path.sv
hw/cpu_cmd_ctrl.sv
hw/zip_dbg_top.sv
testbench/dbg_checker.sv
testbench/tb_zip_dbg.sv

// File: Makefile
TB_TOP := tb_zip_dbg

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f list.f --top-module zip_dbg_top

sim:
	verilator --binary --timing -f list.f --top-module $(TB_TOP) -o V$(TB_TOP)
	@out="$$(./obj_dir/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir
